//--- common/clint_defs.svh
// Hart count, memory-map offsets and register reset values of the CLINT
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// Default number of harts served
`define CLINT_NUM_HARTS 2

// Offsets inside the 64 KB CLINT window
`define CLINT_MSIP_BASE     16'h0000   // 4 bytes per hart
`define CLINT_MTIMECMP_BASE 16'h4000   // 8 bytes per hart
`define CLINT_MTIME_ADDR    16'hBFF8   // Shared counter, 8 bytes

// Reset values
`define CLINT_MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF   // Max compare, no timer irq
`define CLINT_MTIME_RESET    64'h0000_0000_0000_0000

`endif

//--- common/clint_pkg.sv
// Register target and access size enums, byte-lane types, byte merge helper
`default_nettype none

package clint_pkg;

  // ================================================
  // Decoded register target
  // ================================================
  typedef enum logic [1:0] {
    tgt_msip,       // Software interrupt pending, 4 bytes per hart
    tgt_mtimecmp,   // Timer compare, 8 bytes per hart
    tgt_mtime,      // Shared real-time counter
    tgt_none        // Hart index out of range
  } clint_target_e;

  // Request size, log2 of the byte count
  typedef enum logic [2:0] {
    size_byte   = 3'd0,
    size_half   = 3'd1,
    size_word   = 3'd2,
    size_double = 3'd3
  } access_size_e;

  typedef logic [7:0]  byte_en_t;   // One enable per byte lane
  typedef logic [63:0] dword_t;     // Full register width

  // ================================================
  // Byte-masked update of a 64-bit register
  // ================================================
  function automatic dword_t merge_bytes(input dword_t cur, input dword_t nxt,
                                         input byte_en_t be);
    dword_t res;
    res = cur;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = nxt[b*8 +: 8];   // Enabled lane takes new byte
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- common/clint_reg_if.sv
// Decoded register access bundle from the address decoder to the register blocks
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

interface clint_reg_if #(
  parameter int NUM_HARTS = `CLINT_NUM_HARTS
);

  logic                     wr_en;     // Single-cycle write strobe
  logic                     rd_en;     // Single-cycle read strobe
  clint_pkg::clint_target_e target;    // Addressed register
  logic [7:0]               hart;      // Hart index within the region
  clint_pkg::byte_en_t      byte_en;   // Lanes touched by this access
  clint_pkg::dword_t        wdata;     // Write data already lane aligned

  // One-hot hart select, empty when the index is out of range
  function automatic logic [NUM_HARTS-1:0] hart_sel();
    logic [NUM_HARTS-1:0] sel;
    sel = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      sel[h] = (hart == 8'(h));
    end
    return sel;
  endfunction

  modport decoder (
    output wr_en, rd_en, target, hart, byte_en, wdata
  );

  modport sink (
    input  wr_en, rd_en, target, hart, byte_en, wdata,
    import hart_sel
  );

endinterface

`default_nettype wire

//--- clint/clint_decode.sv
// Request decoder: register target, hart index, byte-lane mask and lane-aligned write data
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_decode #(
  parameter int NUM_HARTS = `CLINT_NUM_HARTS
) (
  input  logic                    req_valid,
  input  logic [15:0]             req_addr,
  input  logic                    req_we,
  input  clint_pkg::access_size_e req_size,
  input  clint_pkg::dword_t       req_wdata,
  clint_reg_if.decoder            acc
);

  localparam logic [15:0] MSIP_BASE     = `CLINT_MSIP_BASE;
  localparam logic [15:0] MTIMECMP_BASE = `CLINT_MTIMECMP_BASE;
  localparam logic [15:0] MTIME_ADDR    = `CLINT_MTIME_ADDR;

  logic                is_mtime;    // Hits the shared counter
  logic                is_cmp;      // Hits the mtimecmp region
  logic                is_msip;     // Everything below mtimecmp
  logic [15:0]         hart_idx;    // Full-width index, checked before truncation
  logic                hart_ok;
  logic [2:0]          lane_off;    // Byte offset rounded down to the size
  clint_pkg::byte_en_t lane_mask;   // Unshifted lane mask for the size

  // ================================================
  // Register target and hart index
  // ================================================
  assign is_mtime = (req_addr[15:3] == MTIME_ADDR[15:3]);   // Compare on the dword address
  assign is_cmp   = !is_mtime && (req_addr >= MTIMECMP_BASE);
  assign is_msip  = !is_mtime && !is_cmp;

  // msip is 4 bytes apart, mtimecmp 8 bytes apart
  assign hart_idx = is_cmp ? ((req_addr - MTIMECMP_BASE) >> 3)
                           : ((req_addr - MSIP_BASE) >> 2);
  assign hart_ok  = (hart_idx < 16'(NUM_HARTS));

  always_comb begin
    if (is_mtime) begin
      acc.target = clint_pkg::tgt_mtime;
    end else if (!hart_ok) begin
      acc.target = clint_pkg::tgt_none;     // Beyond the last hart
    end else if (is_cmp) begin
      acc.target = clint_pkg::tgt_mtimecmp;
    end else begin
      acc.target = clint_pkg::tgt_msip;
    end
  end

  assign acc.hart = (is_mtime || !hart_ok) ? 8'h00 : hart_idx[7:0];

  // ================================================
  // Byte lanes
  // ================================================
  // Low address bits under the size are dropped, misaligned access rounds down
  always_comb begin
    case (req_size)
      clint_pkg::size_byte: begin
        lane_off  = req_addr[2:0];
        lane_mask = 8'h01;
      end
      clint_pkg::size_half: begin
        lane_off  = {req_addr[2:1], 1'b0};
        lane_mask = 8'h03;
      end
      clint_pkg::size_word: begin
        lane_off  = {req_addr[2], 2'b00};
        lane_mask = 8'h0F;
      end
      default: begin                        // Double and unused codes
        lane_off  = 3'b000;
        lane_mask = 8'hFF;
      end
    endcase
  end

  // msip only keeps bit 0, so data goes through unshifted
  assign acc.byte_en = is_msip ? lane_mask : clint_pkg::byte_en_t'(lane_mask << lane_off);
  assign acc.wdata   = is_msip ? req_wdata : (req_wdata << {lane_off, 3'b000});

  // Strobes, every request accepted in its own cycle
  assign acc.wr_en = req_valid && req_we;
  assign acc.rd_en = req_valid && !req_we;

endmodule

`default_nettype wire

//--- clint/mtime_counter.sv
// Shared 64-bit machine timer with byte-masked software writes
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module mtime_counter (
  input  logic              clk,
  input  logic              reset_n,
  clint_reg_if.sink         acc,
  output clint_pkg::dword_t mtime
);

  logic mtime_wr;   // Software write to the counter this cycle

  assign mtime_wr = acc.wr_en && (acc.target == clint_pkg::tgt_mtime);

  // ================================================
  // Counter
  // ================================================
  // A write cycle skips the increment; untouched bytes keep the old count
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtime <= `CLINT_MTIME_RESET;
    end else if (mtime_wr) begin
      mtime <= clint_pkg::merge_bytes(mtime, acc.wdata, acc.byte_en);
    end else begin
      mtime <= mtime + 64'd1;             // Free-running tick
    end
  end

endmodule

`default_nettype wire

//--- clint/clint_hart_regs.sv
// Per-hart mtimecmp and msip storage, read select and interrupt generation
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_hart_regs #(
  parameter int NUM_HARTS = `CLINT_NUM_HARTS
) (
  input  logic                 clk,
  input  logic                 reset_n,
  clint_reg_if.sink            acc,
  input  clint_pkg::dword_t    mtime,
  output clint_pkg::dword_t    mtimecmp_rdata,
  output logic                 msip_rdata,
  output logic [NUM_HARTS-1:0] mti,
  output logic [NUM_HARTS-1:0] msi
);

  clint_pkg::dword_t    mtimecmp [NUM_HARTS];   // Compare value per hart
  logic [NUM_HARTS-1:0] msip;                   // Pending bit per hart
  logic [NUM_HARTS-1:0] hart_hit;               // One-hot addressed hart
  logic                 cmp_wr;
  logic                 msip_wr;

  assign cmp_wr   = acc.wr_en && (acc.target == clint_pkg::tgt_mtimecmp);
  assign msip_wr  = acc.wr_en && (acc.target == clint_pkg::tgt_msip);

  // Function reads acc.hart directly
  always_comb begin
    hart_hit = acc.hart_sel();
  end

  // ================================================
  // Storage
  // ================================================
  // Compare registers start at max so no timer fires out of reset
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        mtimecmp[h] <= `CLINT_MTIMECMP_RESET;
      end
    end else if (cmp_wr) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (hart_hit[h]) begin
          mtimecmp[h] <= clint_pkg::merge_bytes(mtimecmp[h], acc.wdata, acc.byte_en);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      msip <= '0;
    end else if (msip_wr) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (hart_hit[h]) begin
          msip[h] <= acc.wdata[0];        // Upper bits are reserved
        end
      end
    end
  end

  // ================================================
  // Read select
  // ================================================
  // Addressed hart's values feed the response mux
  always_comb begin
    mtimecmp_rdata = '0;
    msip_rdata     = 1'b0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (hart_hit[h]) begin
        mtimecmp_rdata = mtimecmp[h];
        msip_rdata     = msip[h];
      end
    end
  end

  // ================================================
  // Interrupts
  // ================================================
  genvar g;
  generate
    for (g = 0; g < NUM_HARTS; g++) begin : gen_mti
      assign mti[g] = (mtime >= mtimecmp[g]);   // Level output that follows compare writes
    end
  endgenerate

  assign msi = msip;

endmodule

`default_nettype wire

//--- clint/clint_response.sv
// Registered read-data select and one-cycle ready pulse
`timescale 1ns/1ps
`default_nettype none

module clint_response (
  input  logic              clk,
  input  logic              reset_n,
  clint_reg_if.sink         acc,
  input  clint_pkg::dword_t mtime,
  input  clint_pkg::dword_t mtimecmp_rdata,
  input  logic              msip_rdata,
  output logic              req_ready,
  output clint_pkg::dword_t req_rdata
);

  clint_pkg::dword_t rd_sel;   // Value of the addressed register before this edge

  // ================================================
  // Read select by target
  // ================================================
  always_comb begin
    case (acc.target)
      clint_pkg::tgt_mtime:    rd_sel = mtime;
      clint_pkg::tgt_mtimecmp: rd_sel = mtimecmp_rdata;
      clint_pkg::tgt_msip:     rd_sel = {63'd0, msip_rdata};
      default:                 rd_sel = '0;   // No hart behind this address
    endcase
  end

  // ================================================
  // Response register
  // ================================================
  // Every strobe answers one cycle later, writes return zero
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_ready <= 1'b0;
      req_rdata <= '0;
    end else begin
      req_ready <= acc.wr_en || acc.rd_en;
      req_rdata <= acc.rd_en ? rd_sel : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/clint_subsystem.sv
// CLINT top level wiring decoder, machine timer, hart registers and response
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_subsystem #(
  parameter int NUM_HARTS = `CLINT_NUM_HARTS
) (
  input  logic                 clk,
  input  logic                 reset_n,
  // Memory-mapped request port
  input  logic                 req_valid,
  input  logic [15:0]          req_addr,
  input  logic [63:0]          req_wdata,
  input  logic                 req_we,
  input  logic [2:0]           req_size,    // 0 byte, 1 half, 2 word, 3 double
  output logic                 req_ready,
  output logic [63:0]          req_rdata,
  // Interrupts, one per hart
  output logic [NUM_HARTS-1:0] mti,
  output logic [NUM_HARTS-1:0] msi
);

  clint_pkg::dword_t mtime;
  clint_pkg::dword_t mtimecmp_rdata;
  logic              msip_rdata;

  clint_reg_if #(.NUM_HARTS(NUM_HARTS)) acc_if ();

  // ================================================
  // Decode, storage and response
  // ================================================
  clint_decode #(.NUM_HARTS(NUM_HARTS)) u_decode (
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_we    (req_we),
    .req_size  (clint_pkg::access_size_e'(req_size)),
    .req_wdata (req_wdata),
    .acc       (acc_if.decoder)
  );

  mtime_counter u_mtime (
    .clk     (clk),
    .reset_n (reset_n),
    .acc     (acc_if.sink),
    .mtime   (mtime)
  );

  clint_hart_regs #(.NUM_HARTS(NUM_HARTS)) u_hart_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .acc            (acc_if.sink),
    .mtime          (mtime),
    .mtimecmp_rdata (mtimecmp_rdata),
    .msip_rdata     (msip_rdata),
    .mti            (mti),
    .msi            (msi)
  );

  clint_response u_response (
    .clk            (clk),
    .reset_n        (reset_n),
    .acc            (acc_if.sink),
    .mtime          (mtime),            // Count before this edge's increment
    .mtimecmp_rdata (mtimecmp_rdata),
    .msip_rdata     (msip_rdata),
    .req_ready      (req_ready),
    .req_rdata      (req_rdata)
  );

endmodule

`default_nettype wire

//--- dv/clint_subsystem_tb.sv
// Stimulus table, register reference model and per-cycle output compare for the CLINT
`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_subsystem_tb;

  localparam int NH      = 2;
  localparam int TIMEOUT = 20;          // Cycles allowed per response
  localparam logic [63:0] CMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;  // mtimecmp after reset
  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_WR   = 2'd2;
  localparam logic [1:0] M_MODEL = 2'd0;  // Random write data checked by the model
  localparam logic [1:0] M_CONST = 2'd1;  // Table data written or read value expected
  localparam logic [1:0] M_B2B   = 2'd2;  // Next entry follows in the next cycle
  localparam logic [1:0] M_NEAR  = 2'd3;  // Write model mtime plus table data

  typedef struct packed {
    logic [1:0]  op;
    logic [15:0] addr;
    logic [2:0]  size;                  // 0 byte, 1 half, 2 word, 3 double
    logic [63:0] data;                  // Idle entries keep their cycle count here
    logic [1:0]  mode;
  } entry_t;

  logic          clk;
  logic          reset_n;
  logic          req_valid;
  logic [15:0]   req_addr;
  logic [63:0]   req_wdata;
  logic          req_we;
  logic [2:0]    req_size;
  logic          req_ready;
  logic [63:0]   req_rdata;
  logic [NH-1:0] mti;
  logic [NH-1:0] msi;

  logic [63:0]   m_mtime;               // Reference model state
  logic [63:0]   m_cmp [NH];
  logic [NH-1:0] m_msip;
  logic          exp_ready;             // Expected response after the last edge
  logic [63:0]   exp_rdata;
  logic [31:0]   rng_state;
  int            errors;
  int            checks;
  entry_t        tbl [$];

  clint_subsystem #(.NUM_HARTS(NH)) uut (
    .clk(clk), .reset_n(reset_n), .req_valid(req_valid), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_we(req_we), .req_size(req_size),
    .req_ready(req_ready), .req_rdata(req_rdata), .mti(mti), .msi(msi)
  );

  always #4 clk = ~clk;                 // 8 ns period

  // ==================================================
  // Reference model helpers
  // ==================================================
  function automatic int hart_of(input logic [15:0] addr);
    if (addr >= `CLINT_MTIMECMP_BASE) begin
      return int'((addr - `CLINT_MTIMECMP_BASE) >> 3);   // 8 bytes per hart
    end
    return int'((addr - `CLINT_MSIP_BASE) >> 2);         // 4 bytes per hart
  endfunction

  // 0 msip, 1 mtimecmp, 2 mtime, 3 no register
  function automatic int target_of(input logic [15:0] addr);
    if ({addr[15:3], 3'b000} == `CLINT_MTIME_ADDR) begin
      return 2;
    end
    if (addr >= `CLINT_MTIMECMP_BASE) begin
      return (hart_of(addr) < NH) ? 1 : 3;
    end
    return (hart_of(addr) < NH) ? 0 : 3;
  endfunction

  // Data byte b lands in lane offset+b with the offset rounded down to the size
  function automatic logic [63:0] merge(input logic [63:0] cur, input logic [63:0] din,
                                        input logic [15:0] addr, input logic [2:0] size);
    logic [63:0] res;
    int          off;
    res = cur;
    off = int'(addr[2:0]) & ~((1 << size) - 1);
    for (int b = 0; b < (1 << size); b++) begin
      res[(off + b)*8 +: 8] = din[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [63:0] model_read(input logic [15:0] addr);
    case (target_of(addr))
      0:       return {63'd0, m_msip[hart_of(addr)]};
      1:       return m_cmp[hart_of(addr)];
      2:       return m_mtime;
      default: return 64'd0;
    endcase
  endfunction

  function automatic logic [NH-1:0] model_mti();
    logic [NH-1:0] v;
    for (int h = 0; h < NH; h++) begin
      v[h] = (m_mtime >= m_cmp[h]);
    end
    return v;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] rand_dword();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi        = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  // Model registers sample the request at the same edge as the DUT
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      m_mtime   <= 64'd0;
      m_msip    <= '0;
      exp_ready <= 1'b0;
      exp_rdata <= 64'd0;
      for (int h = 0; h < NH; h++) begin
        m_cmp[h] <= CMP_RESET;
      end
    end else begin
      exp_ready <= req_valid;
      exp_rdata <= (req_valid && !req_we) ? model_read(req_addr) : 64'd0;  // Pre-edge value
      if (req_valid && req_we && target_of(req_addr) == 2) begin
        m_mtime <= merge(m_mtime, req_wdata, req_addr, req_size);  // No tick on write
      end else begin
        m_mtime <= m_mtime + 64'd1;
      end
      if (req_valid && req_we && target_of(req_addr) == 1) begin
        m_cmp[hart_of(req_addr)] <= merge(m_cmp[hart_of(req_addr)], req_wdata, req_addr,
                                          req_size);
      end
      if (req_valid && req_we && target_of(req_addr) == 0) begin
        m_msip[hart_of(req_addr)] <= req_wdata[0];              // Bit 0 only
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  always @(negedge clk) begin             // Outputs settled mid-cycle
    if (reset_n) begin
      compare_value("req_ready", 64'(req_ready), 64'(exp_ready));
      if (exp_ready) begin
        compare_value("req_rdata", req_rdata, exp_rdata);
      end
      compare_value("mti", 64'(mti), 64'(model_mti()));
      compare_value("msi", 64'(msi), 64'(m_msip));
    end
  end

  task automatic wait_ready(input int idx, output logic [63:0] data, output bit seen);
    int cycles;
    seen   = 1'b0;
    data   = 64'd0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (req_ready) begin
        seen = 1'b1;
        data = req_rdata;
      end
    end
    if (!seen) begin
      errors++;
      $display("Timeout: no req_ready within %0d cycles for table entry %0d", TIMEOUT, idx);
    end
  endtask

  // ==================================================
  // Stimulus table
  // ==================================================
  task automatic add_entry(input logic [1:0] op, input logic [15:0] addr,
                           input logic [2:0] size, input logic [63:0] data,
                           input logic [1:0] mode);
    tbl.push_back(entry_t'{op, addr, size, data, mode});
  endtask

  task automatic build_table();
    add_entry(OP_RD, 16'h4000, 3'd3, CMP_RESET, M_CONST);  // Reset values
    add_entry(OP_RD, 16'h4008, 3'd3, CMP_RESET, M_CONST);
    add_entry(OP_WR, 16'hBFF8, 3'd3, 64'd0, M_MODEL);    // Load mtime and watch it run
    add_entry(OP_RD, 16'hBFF8, 3'd3, 64'd0, M_MODEL);
    add_entry(OP_IDLE, 16'h0000, 3'd0, 64'd3, M_MODEL);
    add_entry(OP_RD, 16'hBFFC, 3'd2, 64'd0, M_MODEL);
    add_entry(OP_WR, 16'h4008, 3'd3, 64'h0123_4567_89AB_CDEF, M_CONST);  // Hart 1 lanes
    add_entry(OP_WR, 16'h400B, 3'd0, 64'd0, M_MODEL);    // Byte at lane 3
    add_entry(OP_RD, 16'h4008, 3'd3, 64'd0, M_MODEL);
    add_entry(OP_WR, 16'h400D, 3'd1, 64'd0, M_MODEL);    // Half rounds down to lane 4
    add_entry(OP_RD, 16'h4008, 3'd3, 64'd0, M_MODEL);
    add_entry(OP_WR, 16'h400E, 3'd2, 64'd0, M_MODEL);    // Word rounds down to lane 4
    add_entry(OP_RD, 16'h4008, 3'd3, 64'd0, M_MODEL);
    add_entry(OP_WR, 16'h0000, 3'd2, 64'd1, M_CONST);    // msip set and clear per hart
    add_entry(OP_RD, 16'h0000, 3'd2, 64'd1, M_CONST);
    add_entry(OP_WR, 16'h0004, 3'd2, 64'd1, M_CONST);
    add_entry(OP_RD, 16'h0004, 3'd2, 64'd1, M_CONST);
    add_entry(OP_WR, 16'h0000, 3'd2, 64'd0, M_CONST);
    add_entry(OP_RD, 16'h0000, 3'd2, 64'd0, M_CONST);
    add_entry(OP_WR, 16'h0004, 3'd2, 64'd0, M_CONST);
    add_entry(OP_RD, 16'h0004, 3'd2, 64'd0, M_CONST);
    add_entry(OP_WR, 16'h0008, 3'd2, 64'd1, M_CONST);    // Hart 2 does not exist
    add_entry(OP_RD, 16'h0008, 3'd2, 64'd0, M_CONST);
    add_entry(OP_RD, 16'h4010, 3'd3, 64'd0, M_CONST);
    add_entry(OP_WR, 16'h0004, 3'd2, 64'd0, M_B2B);      // One request per cycle
    add_entry(OP_RD, 16'h0004, 3'd2, 64'd0, M_B2B);
    add_entry(OP_RD, 16'hBFF8, 3'd3, 64'd0, M_B2B);
    add_entry(OP_WR, 16'h400C, 3'd2, 64'd0, M_B2B);
    add_entry(OP_RD, 16'h4008, 3'd3, 64'd0, M_B2B);
    add_entry(OP_RD, 16'hBFF8, 3'd3, 64'd0, M_MODEL);
    add_entry(OP_WR, 16'h4008, 3'd3, 64'd12, M_NEAR);    // Hart 1 timer a few ticks ahead
    add_entry(OP_IDLE, 16'h0000, 3'd0, 64'd16, M_MODEL);
  endtask

  task automatic run_entry(input int idx);
    entry_t      e;
    logic [63:0] wd;
    logic [63:0] got;
    bit          seen;
    e  = tbl[idx];
    wd = e.data;
    if (e.op == OP_IDLE) begin
      repeat (int'(e.data)) begin
        @(posedge clk);
        req_valid <= 1'b0;
      end
      return;
    end
    @(posedge clk);
    if (e.op == OP_WR && (e.mode == M_MODEL || e.mode == M_B2B)) begin
      wd = rand_dword();
    end
    if (e.mode == M_NEAR) begin
      wd = m_mtime + e.data;            // Model count before this edge
    end
    req_valid <= 1'b1;
    req_we    <= (e.op == OP_WR);
    req_addr  <= e.addr;
    req_size  <= e.size;
    req_wdata <= wd;
    if (e.mode == M_B2B) begin
      return;
    end
    @(posedge clk);
    req_valid <= 1'b0;
    wait_ready(idx, got, seen);
    if (seen && e.op == OP_RD && e.mode == M_CONST) begin
      compare_value("req_rdata", got, e.data);
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk       = 1'b0;
    reset_n   = 1'b0;
    req_valid = 1'b0;
    req_addr  = 16'h0000;
    req_wdata = 64'd0;
    req_we    = 1'b0;
    req_size  = 3'd0;
    errors    = 0;
    checks    = 0;
    rng_state = 32'hcab9;
    build_table();
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    compare_value("mti", 64'(mti), 64'd0);
    compare_value("msi", 64'(msi), 64'd0);
    foreach (tbl[i]) begin
      run_entry(i);
    end
    @(negedge clk);
    compare_value("mti", 64'(mti), 64'(2'b10));   // Hart 1 timer reached while hart 0 stays quiet
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- clint_subsystem.f
+incdir+common
common/clint_pkg.sv
common/clint_reg_if.sv
clint/clint_decode.sv
clint/mtime_counter.sv
clint/clint_hart_regs.sv
clint/clint_response.sv
logic/clint_subsystem.sv
dv/clint_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CLINT testbench with Verilator, run it and scan the log for the pass line
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module clint_subsystem_tb \
  -f clint_subsystem.f \
  -o sim_clint

./obj_dir/sim_clint | tee "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
